// File: filelist.f
+incdir+test
design/sys_pkg.sv
design/hps_cmd_decoder.sv
design/panel_io.sv
design/sync_polarity_fix.sv
design/csync_gen.sv
design/scaler_window.sv
design/sys_top.sv
test/tb_sys_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_sys_top \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	exit 0
else
	exit 1
fi

// File: test/sys_cases.txt
# One action per line: W <hex word> in frame, N <hex word> with frame low, E ends frame
# B <user_n> <osd_n>, L <user> <power> <disk>, K <output> <expected decimal>
K vol 31
K hmin 0
K hmax 1919
K vmin 0
K vmax 1079
K btn_user 0
K btn_osd 0
W 0026
W 000C
K vol 12
E
W 0020
W 0500
W 0010
W 0020
W 0030
W 02D0
W 0005
W 0006
W 0007
E
K hmin 0
K hmax 1279
K vmin 0
K vmax 719
N 0026
N 0003
K vol 12
W 0007
W 0001
E
K vol 12
W 0027
W 01E0
E
K vmin 120
K vmax 599
W 0037
W 0400
E
K hmin 128
K hmax 1151
W 0037
W 0501
E
K hmin 0
K hmax 1279
W 0027
W 0000
E
K vmin 0
K vmax 719
W 0025
W 0F05
E
L 1 3 0
K led 21
L 0 1 3
K led 5
B 0 1
K btn_user 1
K btn_osd 0
B 1 0
K btn_user 0
K btn_osd 1
B 1 1
K btn_osd 0

// File: test/tb_video_tasks.svh
// Host word and sync drive tasks
`ifndef TB_VIDEO_TASKS_SVH
`define TB_VIDEO_TASKS_SVH
`default_nettype none

// One strobe per word, then time for the decoder and the window pipeline
task automatic send_word(input logic [15:0] word, input logic uio);
	@(negedge clk_sys);
	i_io_din = word;
	i_io_uio = uio;
	i_io_clk = 1'b1;
	@(negedge clk_sys);
	i_io_clk = 1'b0;
	repeat (4) @(negedge clk_sys);
endtask

task automatic drop_frame();
	@(negedge clk_sys);
	i_io_uio = 1'b0;
	repeat (2) @(negedge clk_sys);
endtask

////////////////////////////////////////////////////////////
// Inverted sync, low pulse at the start of each line

task automatic run_sync_lines();
	int   line;
	int   pix;
	int   pos;
	logic vs_on;
	logic exp_hs;
	logic exp_vs;
	logic chk_hs;
	logic chk_vs;
	logic chk_cs;
	exp_hs = 1'b0;
	exp_vs = 1'b0;
	chk_hs = 1'b0;
	chk_vs = 1'b0;
	chk_cs = 1'b0;
	for (line = 0; line < SYNC_LINES; line++) begin
		pos   = line % FRAME_LINES;
		vs_on = (pos >= VS_FIRST) && (pos < VS_FIRST + VS_LINES);
		for (pix = 0; pix < LINE_LEN; pix++) begin
			@(negedge clk_sys);
			// Outputs now reflect the levels driven one clock ago
			if (chk_hs)
				check_value("hs_fix", o_hs_fix, exp_hs);
			if (chk_vs)
				check_value("vs_fix", o_vs_fix, exp_vs);
			// csync registered the fixed hsync at the last rising edge
			if (chk_cs)
				check_value("csync", o_csync, exp_hs);
			i_hs_raw = (pix >= HS_LEN);
			i_vs_raw = !vs_on;
			exp_hs   = (pix < HS_LEN);
			exp_vs   = vs_on;
			chk_hs   = (line >= 2);
			// Vertical polarity is settled once the first vsync has passed
			chk_vs   = (line >= FRAME_LINES);
			// Skip the vsync lines and the line right after them
			chk_cs   = (line >= 5) && !(pos >= VS_FIRST && pos <= VS_FIRST + VS_LINES);
		end
	end
	@(negedge clk_sys);
	i_hs_raw = 1'b1;
	i_vs_raw = 1'b1;
endtask

`default_nettype wire
`endif

// File: test/tb_sys_top.sv
// Video system housekeeping testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sys_top;

	// Debounce timing, kept in step with the design
	localparam int DEB_TICK_CLKS = 16;
	localparam int DEB_SAMPLES   = 8;
	localparam int DEB_WAIT      = (DEB_SAMPLES + 2) * DEB_TICK_CLKS;

	// Sync waveform shape
	localparam int LINE_LEN    = 64;
	localparam int HS_LEN      = 8;
	localparam int FRAME_LINES = 8;
	localparam int VS_FIRST    = 2;
	localparam int VS_LINES    = 2;
	localparam int SYNC_LINES  = 24;
	localparam int SYNC_NS     = SYNC_LINES * LINE_LEN * 8 + 2000;

	logic        clk_sys = 1'b0;
	logic        resetd;
	logic [15:0] i_io_din;
	logic        i_io_clk;
	logic        i_io_uio;
	logic        i_led_user;
	logic [1:0]  i_led_power;
	logic [1:0]  i_led_disk;
	logic        i_btn_user_n;
	logic        i_btn_osd_n;
	logic        i_hs_raw;
	logic        i_vs_raw;
	logic [7:0]  o_led;
	logic        o_btn_user;
	logic        o_btn_osd;
	logic [4:0]  o_vol_att;
	logic        o_hs_fix;
	logic        o_vs_fix;
	logic        o_csync;
	logic [11:0] o_hmin;
	logic [11:0] o_hmax;
	logic [11:0] o_vmin;
	logic [11:0] o_vmax;

	string       cases[$];
	int          n_cases = 0;

	sys_top dut_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_din     (i_io_din),
		.i_io_clk     (i_io_clk),
		.i_io_uio     (i_io_uio),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.i_hs_raw     (i_hs_raw),
		.i_vs_raw     (i_vs_raw),
		.o_led        (o_led),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd),
		.o_vol_att    (o_vol_att),
		.o_hs_fix     (o_hs_fix),
		.o_vs_fix     (o_vs_fix),
		.o_csync      (o_csync),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax)
	);

	always #4 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Error handling

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string what, input int actual, input int expected);
		if (actual != expected)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	// Sized from the case count once the file is read
	initial begin
		wait (n_cases > 0);
		#(n_cases * 2000 + SYNC_NS);
		stop_on_error("Timeout: the watchdog ended the run before the tests finished");
	end

	////////////////////////////////////////////////////////////
	// Case file actions

	task automatic run_case(input string line);
		logic [15:0] word;
		logic [95:0] name;
		int          a;
		int          b;
		int          c;
		int          n;
		int          actual;
		actual = 0;
		case (line[0])
			"W": begin
				n = $sscanf(line, "W %h", word);
				send_word(word, 1'b1);
			end
			"N": begin
				n = $sscanf(line, "N %h", word);
				send_word(word, 1'b0);
			end
			"E": drop_frame();
			"B": begin
				n = $sscanf(line, "B %d %d", a, b);
				@(negedge clk_sys);
				i_btn_user_n = a[0];
				i_btn_osd_n  = b[0];
				repeat (DEB_WAIT) @(negedge clk_sys);
			end
			"L": begin
				n = $sscanf(line, "L %d %d %d", a, b, c);
				@(negedge clk_sys);
				i_led_user  = a[0];
				i_led_power = b[1:0];
				i_led_disk  = c[1:0];
				@(negedge clk_sys);
			end
			"K": begin
				n = $sscanf(line, "K %s %d", name, c);
				if (n != 2)
					stop_on_error($sformatf("Malformed check line in case file: %s", line));
				case (name)
					"vol":      actual = o_vol_att;
					"hmin":     actual = o_hmin;
					"hmax":     actual = o_hmax;
					"vmin":     actual = o_vmin;
					"vmax":     actual = o_vmax;
					"led":      actual = o_led;
					"btn_user": actual = o_btn_user;
					"btn_osd":  actual = o_btn_osd;
					default:
						stop_on_error($sformatf("Unknown output name in case file: %0s", name));
				endcase
				check_value($sformatf("%0s", name), actual, c);
			end
			default: stop_on_error($sformatf("Unknown action in case file: %s", line));
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin : main_seq
		int    fd;
		string line;
		resetd       = 1'b1;
		i_io_din     = '0;
		i_io_clk     = 1'b0;
		i_io_uio     = 1'b0;
		i_led_user   = 1'b0;
		i_led_power  = 2'b00;
		i_led_disk   = 2'b00;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		// Idle level of an active-low sync
		i_hs_raw     = 1'b1;
		i_vs_raw     = 1'b1;

		fd = $fopen("test/sys_cases.txt", "r");
		if (fd == 0)
			stop_on_error("Cannot open the case file test/sys_cases.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line[0] != "#" && line[0] != "\n")
				cases.push_back(line);
		end
		$fclose(fd);
		if (cases.size() == 0)
			stop_on_error("The case file holds no actions");
		n_cases = cases.size();

		repeat (2) @(negedge clk_sys);
		resetd = 1'b0;
		// Let the window pipeline fill
		repeat (4) @(negedge clk_sys);

		foreach (cases[i])
			run_case(cases[i]);

		run_sync_lines();

		$display("all tests passed");
		$finish;
	end

	`include "tb_video_tasks.svh"

endmodule

`default_nettype wire

// File: design/sys_top.sv
// Video system housekeeping top
`timescale 1ns/1ps
`default_nettype none

module sys_top import sys_pkg::*; (
	input  wire logic             clk_sys,
	input  wire logic             resetd,
	// Host bus
	input  wire io_word_t         i_io_din,
	input  wire logic             i_io_clk,
	input  wire logic             i_io_uio,
	// Core status and panel
	input  wire logic             i_led_user,
	input  wire logic [1:0]       i_led_power,
	input  wire logic [1:0]       i_led_disk,
	input  wire logic             i_btn_user_n,
	input  wire logic             i_btn_osd_n,
	input  wire logic             i_hs_raw,
	input  wire logic             i_vs_raw,
	output logic [LED_W-1:0]      o_led,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	output logic [VOL_W-1:0]      o_vol_att,
	// Video sync and window
	output logic                  o_hs_fix,
	output logic                  o_vs_fix,
	output logic                  o_csync,
	output logic [DIM_W-1:0]      o_hmin,
	output logic [DIM_W-1:0]      o_hmax,
	output logic [DIM_W-1:0]      o_vmin,
	output logic [DIM_W-1:0]      o_vmax
);

	logic [DIM_W-1:0] cfg_width;
	logic [DIM_W-1:0] cfg_height;
	logic [DIM_W-1:0] vset;
	logic [DIM_W-1:0] hset;
	logic [LED_W-1:0] led_overtake;
	logic [LED_W-1:0] led_state;

	hps_cmd_decoder hps_cmd_decoder_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_din       (i_io_din),
		.i_io_clk       (i_io_clk),
		.i_io_uio       (i_io_uio),
		.o_width        (cfg_width),
		.o_height       (cfg_height),
		.o_vset         (vset),
		.o_hset         (hset),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state),
		.o_vol_att      (o_vol_att)
	);

	panel_io panel_io_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_btn_user_n   (i_btn_user_n),
		.i_btn_osd_n    (i_btn_osd_n),
		.i_led_user     (i_led_user),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_led_overtake (led_overtake),
		.i_led_state    (led_state),
		.o_btn_user     (o_btn_user),
		.o_btn_osd      (o_btn_osd),
		.o_led          (o_led)
	);

	sync_polarity_fix sync_fix_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs_fix)
	);

	sync_polarity_fix sync_fix_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_raw),
		.o_sync  (o_vs_fix)
	);

	csync_gen csync_gen_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (o_hs_fix),
		.i_vs    (o_vs_fix),
		.o_csync (o_csync)
	);

	scaler_window scaler_window_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_width  (cfg_width),
		.i_height (cfg_height),
		.i_vset   (vset),
		.i_hset   (hset),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

endmodule

`default_nettype wire

// File: design/scaler_window.sv
// Scaler output window
`timescale 1ns/1ps
`default_nettype none

module scaler_window import sys_pkg::*; (
	input  wire logic             clk_sys,
	input  wire logic             resetd,
	input  wire logic [DIM_W-1:0] i_width,
	input  wire logic [DIM_W-1:0] i_height,
	input  wire logic [DIM_W-1:0] i_vset,
	input  wire logic [DIM_W-1:0] i_hset,
	output logic [DIM_W-1:0]      o_hmin,
	output logic [DIM_W-1:0]      o_hmax,
	output logic [DIM_W-1:0]      o_vmin,
	output logic [DIM_W-1:0]      o_vmax
);

	logic [DIM_W-1:0] width_q;
	logic [DIM_W-1:0] height_q;
	logic [DIM_W-1:0] used_w;
	logic [DIM_W-1:0] used_h;
	logic [DIM_W-1:0] hpad;
	logic [DIM_W-1:0] vpad;

	// Half the unused border on each side
	assign hpad = (width_q - used_w) >> 1;
	assign vpad = (height_q - used_h) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			width_q  <= '0;
			height_q <= '0;
			used_w   <= '0;
			used_h   <= '0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			// Stage 1, limit the used size
			width_q  <= i_width;
			height_q <= i_height;
			used_w   <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			used_h   <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

			// Stage 2, center the window
			o_hmin <= hpad;
			o_hmax <= hpad + used_w - 1'b1;
			o_vmin <= vpad;
			o_vmax <= vpad + used_h - 1'b1;
		end
	end

	a_window_order: assert property (@(posedge clk_sys) disable iff (resetd)
		(o_hmax >= o_hmin) && (o_vmax >= o_vmin));

endmodule

`default_nettype wire

// File: design/csync_gen.sv
// Composite sync generator
`timescale 1ns/1ps
`default_nettype none

module csync_gen import sys_pkg::*; (
	input  wire logic clk_sys,
	input  wire logic resetd,
	input  wire logic i_hs,
	input  wire logic i_vs,
	output logic      o_csync
);

	logic                  hs_d;
	logic                  vs_q;
	logic                  pulse;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			vs_q     <= 1'b0;
			pulse    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_d <= i_hs;
			vs_q <= i_vs;

			// Counter restarts on each hsync edge
			if (hs_d != i_hs) begin
				h_cnt <= '0;
				if (i_hs)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// Serration pulse, shifted one hsync length early
			if (!i_vs)
				pulse <= i_hs;
			else if (i_hs & ~hs_d)
				pulse <= 1'b0;
			else if (h_cnt == line_len)
				pulse <= 1'b1;
		end
	end

	// Plain hsync outside vsync, inverted serration inside
	assign o_csync = vs_q ^ pulse;

endmodule

`default_nettype wire

// File: design/sync_polarity_fix.sv
// Sync polarity normalizer
`timescale 1ns/1ps
`default_nettype none

module sync_polarity_fix import sys_pkg::*; (
	input  wire logic clk_sys,
	input  wire logic resetd,
	input  wire logic i_sync,
	output logic      o_sync
);

	logic                  sync_q;
	logic                  sync_d;
	logic                  rise;
	logic                  fall;
	logic [SYNC_CNT_W-1:0] run_cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;
	logic                  pol;

	assign rise = sync_q & ~sync_d;
	assign fall = ~sync_q & sync_d;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_q  <= 1'b0;
			sync_d  <= 1'b0;
			run_cnt <= '0;
			hi_len  <= '0;
			lo_len  <= '0;
			pol     <= 1'b0;
		end else begin
			sync_q <= i_sync;
			sync_d <= sync_q;

			// Length of the current level, held at full scale
			if (rise | fall)
				run_cnt <= '0;
			else if (run_cnt != '1)
				run_cnt <= run_cnt + 1'b1;

			// A low period just ended
			if (rise) begin
				lo_len <= run_cnt;
				pol    <= hi_len > run_cnt;
			end
			// A high period just ended
			if (fall) begin
				hi_len <= run_cnt;
				pol    <= run_cnt > lo_len;
			end
		end
	end

	// Longer high level means the sync is active low
	assign o_sync = i_sync ^ pol;

endmodule

`default_nettype wire

// File: design/panel_io.sv
// Buttons and main board LEDs
`timescale 1ns/1ps
`default_nettype none

module panel_io import sys_pkg::*; (
	input  wire logic             clk_sys,
	input  wire logic             resetd,
	input  wire logic             i_btn_user_n,
	input  wire logic             i_btn_osd_n,
	input  wire logic             i_led_user,
	input  wire logic [1:0]       i_led_power,
	input  wire logic [1:0]       i_led_disk,
	input  wire logic [LED_W-1:0] i_led_overtake,
	input  wire logic [LED_W-1:0] i_led_state,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	output logic [LED_W-1:0]      o_led
);

	logic [DEB_DIV_W-1:0] div;
	logic                 tick;
	logic [1:0]           btn_raw;
	logic [DEB_LEN-1:0]   deb_sr   [2];
	logic [DEB_LEN-1:0]   deb_next [2];
	logic [1:0]           btn_q;
	logic                 power_on;
	logic                 disk_on;

	////////////////////////////////////////////////////////////
	// Debounce

	// Index 0 is the user button, index 1 the OSD button
	assign btn_raw = ~{i_btn_osd_n, i_btn_user_n};
	assign tick    = (div == DEB_DIV_W'(DEB_TICK - 1));

	always_comb begin
		for (int i = 0; i < 2; i++)
			deb_next[i] = {deb_sr[i][DEB_LEN-2:0], btn_raw[i]};
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div   <= '0;
			btn_q <= '0;
			for (int i = 0; i < 2; i++)
				deb_sr[i] <= '0;
		end else begin
			div <= tick ? '0 : div + 1'b1;
			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					deb_sr[i] <= deb_next[i];
					if (&deb_next[i])
						btn_q[i] <= 1'b1;
					if (~|deb_next[i])
						btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	////////////////////////////////////////////////////////////
	// LEDs

	assign power_on = i_led_power[1] ? i_led_power[0] : 1'b0;
	// Disk LED shows its own value bit whether or not it is overridden
	assign disk_on  = i_led_disk[0];

	assign o_led = (i_led_overtake & i_led_state) |
		(~i_led_overtake & {3'b000, power_on, 1'b0, disk_on, 1'b0, i_led_user});

endmodule

`default_nettype wire

// File: design/hps_cmd_decoder.sv
// Host command decoder
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_decoder import sys_pkg::*; (
	input  wire logic             clk_sys,
	input  wire logic             resetd,
	input  wire io_word_t         i_io_din,
	input  wire logic             i_io_clk,
	input  wire logic             i_io_uio,
	output logic [DIM_W-1:0]      o_width,
	output logic [DIM_W-1:0]      o_height,
	output logic [DIM_W-1:0]      o_vset,
	output logic [DIM_W-1:0]      o_hset,
	output logic [LED_W-1:0]      o_led_overtake,
	output logic [LED_W-1:0]      o_led_state,
	output logic [VOL_W-1:0]      o_vol_att
);

	logic                  io_clk_q;
	logic                  io_clk_d;
	io_word_t              din_q;
	logic                  strobe;
	logic                  has_cmd;
	logic [7:0]            cmd;
	logic [WORD_CNT_W-1:0] word_cnt;

	// Word is captured together with the strobe sample
	always_ff @(posedge clk_sys) begin
		din_q <= i_io_din;
	end

	// One cycle pulse on the sampled strobe rise
	assign strobe = io_clk_q & ~io_clk_d;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_q       <= 1'b0;
			io_clk_d       <= 1'b0;
			has_cmd        <= 1'b0;
			cmd            <= '0;
			word_cnt       <= '0;
			o_width        <= DEF_WIDTH;
			o_height       <= DEF_HEIGHT;
			o_vset         <= '0;
			o_hset         <= '0;
			o_led_overtake <= '0;
			o_led_state    <= '0;
			o_vol_att      <= DEF_VOL_ATT;
		end else begin
			io_clk_q <= i_io_clk;
			io_clk_d <= io_clk_q;

			if (!i_io_uio) begin
				// Frame closed, next word opens a new command
				has_cmd <= 1'b0;
				cmd     <= '0;
			end else if (strobe) begin
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd      <= din_q.cmd.code;
					word_cnt <= '0;
				end else begin
					if (word_cnt != '1)
						word_cnt <= word_cnt + 1'b1;

					case (cmd)
						CMD_TIMING: begin
							// Porches and sync widths are not used here
							if (word_cnt == TIMING_WORD_WIDTH)
								o_width <= din_q.param.value;
							if (word_cnt == TIMING_WORD_HEIGHT)
								o_height <= din_q.param.value;
						end
						CMD_LED: begin
							{o_led_overtake, o_led_state} <= din_q;
						end
						CMD_VOLUME: begin
							o_vol_att <= din_q.param.value[VOL_W-1:0];
						end
						CMD_VSET: begin
							o_vset <= din_q.param.value;
						end
						CMD_HSET: begin
							o_hset <= din_q.param.value;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Any config register change must come from a word taken under a held command
	a_write_needs_cmd: assert property (@(posedge clk_sys) disable iff (resetd)
		!$stable({o_width, o_height, o_vset, o_hset, o_led_overtake, o_led_state, o_vol_att})
		|-> $past(has_cmd && i_io_uio && strobe));

endmodule

`default_nettype wire

// File: design/sys_pkg.sv
// Video system shared definitions
`default_nettype none

package sys_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	localparam int DIM_W      = 12;
	localparam int LED_W      = 8;
	localparam int VOL_W      = 5;
	localparam int SYNC_CNT_W = 16;
	localparam int WORD_CNT_W = 4;

	////////////////////////////////////////////////////////////
	// Host command codes

	localparam logic [7:0] CMD_TIMING = 8'h20;
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VOLUME = 8'h26;
	localparam logic [7:0] CMD_VSET   = 8'h27;
	localparam logic [7:0] CMD_HSET   = 8'h37;

	// Word positions inside the timing command
	localparam logic [WORD_CNT_W-1:0] TIMING_WORD_WIDTH  = 4'd0;
	localparam logic [WORD_CNT_W-1:0] TIMING_WORD_HEIGHT = 4'd4;

	////////////////////////////////////////////////////////////
	// Reset values

	localparam logic [DIM_W-1:0] DEF_WIDTH   = 12'd1920;
	localparam logic [DIM_W-1:0] DEF_HEIGHT  = 12'd1080;
	localparam logic [VOL_W-1:0] DEF_VOL_ATT = 5'd31;

	// Button debounce
	localparam int DEB_TICK  = 16;
	localparam int DEB_LEN   = 8;
	localparam int DEB_DIV_W = $clog2(DEB_TICK);

	////////////////////////////////////////////////////////////
	// Host word, seen as a command code or as a parameter

	typedef union packed {
		struct packed {
			logic [7:0] rsvd;
			logic [7:0] code;
		} cmd;
		struct packed {
			logic             flag;
			logic [2:0]       rsvd;
			logic [DIM_W-1:0] value;
		} param;
	} io_word_t;

endpackage

`default_nettype wire
